/* list.f */
+incdir+design
design/rope_pkg.sv
design/uart_rx.sv
design/hex_line_parser.sv
design/rope_regs.sv
design/rope_game_periph.sv
bench/tb_rope_game.sv

/* run_sim.sh */
#!/bin/sh
# Build the rope game testbench with Verilator, run it and check the log

rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module tb_rope_game -f list.f -o sim_rope_game \
   && ./obj_dir/sim_rope_game | tee sim.log

grep -q -F "*** TEST PASSED ***" sim.log \
   && echo "Simulation run passed" \
   || { echo "Simulation run failed"; exit 1; }

/* bench/tb_rope_game.sv */
`default_nettype none

`include "rope_consts.svh"

module tb_rope_game;
   timeunit 1ns;
   timeprecision 1ps;

   import rope_pkg::*;

   localparam int CLK_DIV     = 2;
   localparam int BIT_CLKS    = CLK_DIV * `RG_OVERSAMPLE;
   // Start, 8 data and stop bit at 8 ns per clock
   localparam int CHAR_NS     = 10 * BIT_CLKS * 8;
   localparam int NUM_CHARS   = 33;
   localparam int WATCHDOG_NS = (3 * NUM_CHARS * CHAR_NS) / 2 + 20000;

   logic      clk = 1'b0;
   logic      arst_n;
   logic      psel;
   logic      penable;
   logic      pwrite;
   apb_addr_t paddr;
   word_t     pwdata;
   word_t     prdata;
   logic      pready;
   logic      pslverr;
   logic      ble_txd;
   rope_loc_t rope_loc;
   logic      song_start;
   logic      irq;

   int        seed = 73;
   int        errs_in_test = 0;
   int        total_errors = 0;
   int        tests_run = 0;
   int        tests_failed = 0;
   word_t     accel_exp = '0;
   word_t     rope_exp = '0;

   rope_game_periph #(
      .CLK_DIV (CLK_DIV)
   ) dut (
      .clk          (clk),
      .i_arst_n     (arst_n),
      .i_psel       (psel),
      .i_penable    (penable),
      .i_pwrite     (pwrite),
      .i_paddr      (paddr),
      .i_pwdata     (pwdata),
      .o_prdata     (prdata),
      .o_pready     (pready),
      .o_pslverr    (pslverr),
      .i_ble_txd    (ble_txd),
      .o_rope_loc   (rope_loc),
      .o_song_start (song_start),
      .o_irq        (irq)
   );

   always #4 clk = ~clk;

   initial begin
      #(WATCHDOG_NS);
      $display("Watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
      $display("*** TEST FAILED ***");
      $finish;
   end

   //**************************************************************************
   // Helpers
   //**************************************************************************

   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic idle(input int n);
      repeat (n) next_cycle();
   endtask

   task automatic check(input string name, input word_t got, input word_t exp);
      assert (got === exp) else begin
         $display("Mismatch at %0t: %s is 0x%08h, expected 0x%08h", $time, name, got, exp);
         errs_in_test++;
      end
   endtask

   function automatic logic is_mapped(input apb_addr_t a);
      return a == `RG_OFS_ACCEL || a == `RG_OFS_ROPE || a == `RG_OFS_CTRL ||
             a == `RG_OFS_STATUS;
   endfunction

   // Digit 0-9 or letter in the requested case
   function automatic byte_t hex_char(input logic [3:0] n, input logic upper);
      if (n < 4'd10) begin
         return {4'h3, n};
      end
      return upper ? (8'h37 + {4'h0, n}) : (8'h57 + {4'h0, n});
   endfunction

   // 8N1 frame sent LSB first
   task automatic send_char(input byte_t c);
      ble_txd = 1'b0;
      idle(BIT_CLKS);
      for (int i = 0; i < `RG_DATA_BITS; i++) begin
         ble_txd = c[i];
         idle(BIT_CLKS);
      end
      ble_txd = 1'b1;
      idle(BIT_CLKS);
   endtask

   task automatic send_line(input string s, input byte_t term);
      for (int i = 0; i < s.len(); i++) begin
         send_char(s[i]);
      end
      send_char(term);
   endtask

   task automatic send_hex_word(input word_t v);
      for (int i = 7; i >= 0; i--) begin
         send_char(hex_char(v[i*4 +: 4], i[0]));
      end
      send_char(`RG_ASCII_LF);
   endtask

   // Setup phase, then access phase with outputs sampled mid-cycle
   task automatic apb_access(input logic write, input apb_addr_t addr, input word_t wdata,
                             output word_t rdata);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = write;
      paddr   = addr;
      pwdata  = wdata;
      next_cycle();
      penable = 1'b1;
      #3;
      rdata = prdata;
      check("o_pready", 32'(pready), 32'h1);
      check("o_pslverr", 32'(pslverr), 32'(!is_mapped(addr)));
      next_cycle();
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic apb_write(input apb_addr_t addr, input word_t data);
      word_t unused;
      apb_access(1'b1, addr, data, unused);
   endtask

   task automatic apb_read(input apb_addr_t addr, output word_t data);
      apb_access(1'b0, addr, '0, data);
   endtask

   task automatic check_reg(input string name, input apb_addr_t addr, input word_t exp);
      word_t data;
      apb_read(addr, data);
      check(name, data, exp);
   endtask

   task automatic wait_irq();
      int n;
      n = 0;
      while (!irq && n < 2 * BIT_CLKS) begin
         next_cycle();
         n++;
      end
      assert (irq) else begin
         $display("At %0t o_irq did not rise within %0d cycles of the line end", $time, n);
         errs_in_test++;
      end
   endtask

   task automatic report_test(input string name);
      if (errs_in_test == 0) begin
         $display("%s: ok", name);
      end else begin
         $display("%s: failed with %0d errors", name, errs_in_test);
         tests_failed++;
      end
      total_errors += errs_in_test;
      tests_run++;
      errs_in_test = 0;
   endtask

   //**************************************************************************
   // Directed tests
   //**************************************************************************

   task automatic reset_and_rope_access();
      word_t v;
      // Bus idle after reset
      check("o_pready", 32'(pready), 32'h0);
      check("o_pslverr", 32'(pslverr), 32'h0);
      check_reg("ROPE", `RG_OFS_ROPE, 32'h0);
      check_reg("STATUS", `RG_OFS_STATUS, 32'h0);
      check_reg("ACCEL", `RG_OFS_ACCEL, 32'h0);
      check("o_irq", 32'(irq), 32'h0);
      check("o_rope_loc", 32'(rope_loc), 32'h0);
      for (int i = 0; i < 4; i++) begin
         v = $random(seed);
         apb_write(`RG_OFS_ROPE, v);
         // Only the low 10 bits are stored
         rope_exp = {22'h0, v[9:0]};
         check_reg("ROPE", `RG_OFS_ROPE, rope_exp);
         check("o_rope_loc", 32'(rope_loc), rope_exp);
      end
      report_test("reset and ROPE access");
   endtask

   task automatic hex_word_line();
      word_t v;
      v = $random(seed);
      send_hex_word(v);
      wait_irq();
      accel_exp = v;
      check_reg("STATUS", `RG_OFS_STATUS, 32'h1);
      check_reg("ACCEL", `RG_OFS_ACCEL, accel_exp);
      check_reg("STATUS", `RG_OFS_STATUS, 32'h0);
      check("o_irq", 32'(irq), 32'h0);
      report_test("hex word line");
   endtask

   task automatic short_and_empty_lines();
      send_line("7F", `RG_ASCII_CR);
      wait_irq();
      accel_exp = 32'h7F;
      check_reg("ACCEL", `RG_OFS_ACCEL, accel_exp);
      // Lone terminator is dropped
      send_line("", `RG_ASCII_LF);
      idle(4);
      check("o_irq", 32'(irq), 32'h0);
      check_reg("STATUS", `RG_OFS_STATUS, 32'h0);
      check_reg("ACCEL", `RG_OFS_ACCEL, accel_exp);
      report_test("short and empty lines");
   endtask

   task automatic bad_lines();
      send_line("12G4", `RG_ASCII_LF);
      idle(4);
      check_reg("STATUS", `RG_OFS_STATUS, 32'h2);
      check_reg("ACCEL", `RG_OFS_ACCEL, accel_exp);
      apb_write(`RG_OFS_STATUS, 32'h2);
      check_reg("STATUS", `RG_OFS_STATUS, 32'h0);
      // Ninth digit overflows the line
      send_line("123456789", `RG_ASCII_LF);
      idle(4);
      check_reg("STATUS", `RG_OFS_STATUS, 32'h2);
      check_reg("ACCEL", `RG_OFS_ACCEL, accel_exp);
      apb_write(`RG_OFS_STATUS, 32'h2);
      check_reg("STATUS", `RG_OFS_STATUS, 32'h0);
      send_line("BEEF", `RG_ASCII_CR);
      wait_irq();
      accel_exp = 32'hBEEF;
      check_reg("ACCEL", `RG_OFS_ACCEL, accel_exp);
      report_test("bad lines");
   endtask

   task automatic song_and_bus_errors();
      check("o_song_start", 32'(song_start), 32'h0);
      apb_write(`RG_OFS_CTRL, 32'h1);
      // High in the cycle after the access phase only
      check("o_song_start", 32'(song_start), 32'h1);
      next_cycle();
      check("o_song_start", 32'(song_start), 32'h0);
      check_reg("CTRL", `RG_OFS_CTRL, 32'h0);
      check_reg("offset 0xE", 4'hE, 32'h0);
      apb_write(4'hE, 32'h3FF);
      check_reg("ROPE", `RG_OFS_ROPE, rope_exp);
      report_test("song start and bus errors");
   endtask

   initial begin
      arst_n  = 1'b0;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = '0;
      pwdata  = '0;
      ble_txd = 1'b1;
      repeat (2) @(posedge clk);
      #1;
      arst_n = 1'b1;
      next_cycle();

      reset_and_rope_access();
      hex_word_line();
      short_and_empty_lines();
      bad_lines();
      song_and_bus_errors();

      $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors);
      if (total_errors == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* design/rope_game_periph.sv */
`default_nettype none

`include "rope_consts.svh"

module rope_game_periph #(
   parameter int CLK_DIV = `RG_BAUD_DIV
) (
   input  wire                      clk,
   input  wire                      i_arst_n,
   // APB slave
   input  wire                      i_psel,
   input  wire                      i_penable,
   input  wire                      i_pwrite,
   input  wire rope_pkg::apb_addr_t i_paddr,
   input  wire rope_pkg::word_t     i_pwdata,
   output rope_pkg::word_t          o_prdata,
   output logic                     o_pready,
   output logic                     o_pslverr,
   // TXD of the BLE module
   input  wire                      i_ble_txd,
   // Game side
   output rope_pkg::rope_loc_t      o_rope_loc,
   output logic                     o_song_start,
   output logic                     o_irq
);
   import rope_pkg::*;

   logic  byte_valid;
   byte_t rx_byte;
   logic  frame_err;
   logic  value_valid;
   word_t value;
   logic  line_err;

   //**************************************************************************
   // Serial path into the register block
   //**************************************************************************

   uart_rx #(
      .CLK_DIV (CLK_DIV)
   ) u_uart_rx (
      .clk          (clk),
      .i_arst_n     (i_arst_n),
      .i_rx         (i_ble_txd),
      .o_byte_valid (byte_valid),
      .o_byte       (rx_byte),
      .o_frame_err  (frame_err)
   );

   hex_line_parser u_parser (
      .clk           (clk),
      .i_arst_n      (i_arst_n),
      .i_byte_valid  (byte_valid),
      .i_byte        (rx_byte),
      .i_frame_err   (frame_err),
      .o_value_valid (value_valid),
      .o_value       (value),
      .o_line_err    (line_err)
   );

   rope_regs u_regs (
      .clk           (clk),
      .i_arst_n      (i_arst_n),
      .i_psel        (i_psel),
      .i_penable     (i_penable),
      .i_pwrite      (i_pwrite),
      .i_paddr       (i_paddr),
      .i_pwdata      (i_pwdata),
      .o_prdata      (o_prdata),
      .o_pready      (o_pready),
      .o_pslverr     (o_pslverr),
      .i_value_valid (value_valid),
      .i_value       (value),
      .i_line_err    (line_err),
      .o_rope_loc    (o_rope_loc),
      .o_song_start  (o_song_start),
      .o_irq         (o_irq)
   );

endmodule

`default_nettype wire

/* design/rope_regs.sv */
`default_nettype none

`include "rope_consts.svh"

module rope_regs (
   input  wire                      clk,
   input  wire                      i_arst_n,
   input  wire                      i_psel,
   input  wire                      i_penable,
   input  wire                      i_pwrite,
   input  wire rope_pkg::apb_addr_t i_paddr,
   input  wire rope_pkg::word_t     i_pwdata,
   output rope_pkg::word_t          o_prdata,
   output logic                     o_pready,
   output logic                     o_pslverr,
   input  wire                      i_value_valid,
   input  wire rope_pkg::word_t     i_value,
   input  wire                      i_line_err,
   output rope_pkg::rope_loc_t      o_rope_loc,
   output logic                     o_song_start,
   output logic                     o_irq
);
   import rope_pkg::*;

   localparam int ST_NEW = 0;
   localparam int ST_ERR = 1;

   logic  access;
   logic  sel_accel;
   logic  sel_rope;
   logic  sel_ctrl;
   logic  sel_status;
   logic  addr_ok;
   logic  wr;
   logic  rd;
   logic  clr_new;
   logic  new_flag;
   logic  err_flag;
   word_t accel;

   //**************************************************************************
   // APB decode without wait states
   //**************************************************************************

   assign access     = i_psel && i_penable;
   assign sel_accel  = (i_paddr == `RG_OFS_ACCEL);
   assign sel_rope   = (i_paddr == `RG_OFS_ROPE);
   assign sel_ctrl   = (i_paddr == `RG_OFS_CTRL);
   assign sel_status = (i_paddr == `RG_OFS_STATUS);
   assign addr_ok    = sel_accel || sel_rope || sel_ctrl || sel_status;

   assign wr        = access && i_pwrite && addr_ok;
   assign rd        = access && !i_pwrite;
   assign o_pready  = access;
   assign o_pslverr = access && !addr_ok;

   // Unmapped offsets and CTRL read back zero
   always_comb begin
      o_prdata = '0;
      if (rd) begin
         if (sel_accel) begin
            o_prdata = accel;
         end else if (sel_rope) begin
            o_prdata = word_t'(o_rope_loc);
         end else if (sel_status) begin
            o_prdata[ST_NEW] = new_flag;
            o_prdata[ST_ERR] = err_flag;
         end
      end
   end

   //**************************************************************************
   // Registers
   //**************************************************************************

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         accel        <= '0;
         o_rope_loc   <= '0;
         o_song_start <= 1'b0;
      end else begin
         if (i_value_valid) begin
            accel <= i_value;
         end
         if (wr && sel_rope) begin
            o_rope_loc <= i_pwdata[$bits(rope_loc_t)-1:0];
         end
         // One-cycle pulse after the access phase
         o_song_start <= wr && sel_ctrl && i_pwdata[0];
      end
   end

   // Reading ACCEL acknowledges the new value as well
   assign clr_new = (rd && sel_accel) || (wr && sel_status && i_pwdata[ST_NEW]);

   // A value arriving with a clear wins
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         new_flag <= 1'b0;
         err_flag <= 1'b0;
      end else begin
         if (i_value_valid) begin
            new_flag <= 1'b1;
         end else if (clr_new) begin
            new_flag <= 1'b0;
         end
         if (i_line_err) begin
            err_flag <= 1'b1;
         end else if (wr && sel_status && i_pwdata[ST_ERR]) begin
            err_flag <= 1'b0;
         end
      end
   end

   assign o_irq = new_flag;

endmodule

`default_nettype wire

/* design/hex_line_parser.sv */
`default_nettype none

`include "rope_consts.svh"

module hex_line_parser (
   input  wire                  clk,
   input  wire                  i_arst_n,
   input  wire                  i_byte_valid,
   input  wire rope_pkg::byte_t i_byte,
   input  wire                  i_frame_err,
   output logic                 o_value_valid,
   output rope_pkg::word_t      o_value,
   output logic                 o_line_err
);
   import rope_pkg::*;

   word_t      acc;
   digit_cnt_t digit_cnt;
   logic       poisoned;
   logic       is_term;
   logic       is_hex;
   logic [3:0] nibble;
   logic       digit_ok;

   assign is_term = (i_byte == `RG_ASCII_CR) || (i_byte == `RG_ASCII_LF);

   // ASCII hex to nibble in either case
   always_comb begin
      is_hex = 1'b1;
      nibble = '0;
      if (i_byte >= "0" && i_byte <= "9") begin
         nibble = i_byte[3:0];
      end else if ((i_byte >= "A" && i_byte <= "F") || (i_byte >= "a" && i_byte <= "f")) begin
         nibble = i_byte[3:0] + 4'd9;
      end else begin
         is_hex = 1'b0;
      end
   end

   assign digit_ok = i_byte_valid && is_hex &&
                     (digit_cnt != digit_cnt_t'(`RG_MAX_DIGITS));

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         digit_cnt     <= '0;
         poisoned      <= 1'b0;
         o_value_valid <= 1'b0;
         o_line_err    <= 1'b0;
      end else begin
         o_value_valid <= 1'b0;
         o_line_err    <= 1'b0;
         if (i_frame_err) begin
            poisoned <= 1'b1;
         end else if (i_byte_valid) begin
            if (is_term) begin
               // Empty clean line is dropped silently
               o_line_err    <= poisoned;
               o_value_valid <= !poisoned && (digit_cnt != '0);
               digit_cnt     <= '0;
               poisoned      <= 1'b0;
            end else if (digit_ok) begin
               digit_cnt <= digit_cnt + 1'b1;
            end else begin
               poisoned <= 1'b1;
            end
         end
      end
   end

   // First digit of a line clears the upper nibbles
   always_ff @(posedge clk) begin
      if (digit_ok) begin
         acc <= (digit_cnt == '0) ? word_t'(nibble) : {acc[$bits(word_t)-5:0], nibble};
      end
   end

   // Still holds the line after the terminator
   assign o_value = acc;

endmodule

`default_nettype wire

/* design/uart_rx.sv */
`default_nettype none

`include "rope_consts.svh"

module uart_rx #(
   parameter int CLK_DIV = `RG_BAUD_DIV
) (
   input  wire             clk,
   input  wire             i_arst_n,
   input  wire             i_rx,
   output logic            o_byte_valid,
   output rope_pkg::byte_t o_byte,
   output logic            o_frame_err
);
   import rope_pkg::*;

   localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
   localparam int OS_W  = $clog2(`RG_OVERSAMPLE);
   localparam int BIT_W = $clog2(`RG_DATA_BITS);

   localparam logic [OS_W-1:0]  OS_MID   = OS_W'(`RG_OVERSAMPLE / 2 - 1);
   localparam logic [OS_W-1:0]  OS_LAST  = OS_W'(`RG_OVERSAMPLE - 1);
   localparam logic [BIT_W-1:0] BIT_LAST = BIT_W'(`RG_DATA_BITS - 1);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_START,
      ST_DATA,
      ST_STOP
   } state_t;

   state_t           state;
   logic             rx_meta;
   logic             rx_sync;
   logic [DIV_W-1:0] div_cnt;
   logic             tick;
   logic [OS_W-1:0]  os_cnt;
   logic [BIT_W-1:0] bit_cnt;
   logic             bit_mid;
   byte_t            shreg;

   // Two-flop synchronizer that resets to the idle high level
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         rx_meta <= 1'b1;
         rx_sync <= 1'b1;
      end else begin
         rx_meta <= i_rx;
         rx_sync <= rx_meta;
      end
   end

   // Oversample tick generator
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         div_cnt <= '0;
      end else if (tick) begin
         div_cnt <= '0;
      end else begin
         div_cnt <= div_cnt + 1'b1;
      end
   end

   assign tick    = (div_cnt == DIV_W'(CLK_DIV - 1));
   // Middle of a data or stop bit once aligned by the start bit
   assign bit_mid = tick && (os_cnt == OS_LAST);

   //**************************************************************************
   // Receive FSM
   //**************************************************************************

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         state        <= ST_IDLE;
         os_cnt       <= '0;
         bit_cnt      <= '0;
         o_byte_valid <= 1'b0;
         o_frame_err  <= 1'b0;
      end else begin
         o_byte_valid <= 1'b0;
         o_frame_err  <= 1'b0;
         case (state)
            ST_IDLE: begin
               os_cnt <= '0;
               if (!rx_sync) begin
                  state <= ST_START;
               end
            end
            ST_START: begin
               if (tick) begin
                  if (os_cnt == OS_MID) begin
                     os_cnt  <= '0;
                     bit_cnt <= '0;
                     // High again at mid-bit means a glitch
                     state   <= rx_sync ? ST_IDLE : ST_DATA;
                  end else begin
                     os_cnt <= os_cnt + 1'b1;
                  end
               end
            end
            ST_DATA: begin
               if (tick) begin
                  os_cnt <= os_cnt + 1'b1;
               end
               if (bit_mid) begin
                  bit_cnt <= bit_cnt + 1'b1;
                  if (bit_cnt == BIT_LAST) begin
                     state <= ST_STOP;
                  end
               end
            end
            default: begin
               if (tick) begin
                  os_cnt <= os_cnt + 1'b1;
               end
               if (bit_mid) begin
                  o_byte_valid <= rx_sync;
                  o_frame_err  <= !rx_sync;
                  state        <= ST_IDLE;
               end
            end
         endcase
      end
   end

   // LSB first
   always_ff @(posedge clk) begin
      if (state == ST_DATA && bit_mid) begin
         shreg <= {rx_sync, shreg[`RG_DATA_BITS-1:1]};
      end
   end

   assign o_byte = shreg;

endmodule

`default_nettype wire

/* design/rope_pkg.sv */
`default_nettype none

`include "rope_consts.svh"

//**************************************************************************
// Shared types of the rope game peripheral
//**************************************************************************

package rope_pkg;

   // One character off the serial line
   typedef logic [`RG_DATA_BITS-1:0] byte_t;

   // APB data word and the accelerometer value
   typedef logic [31:0] word_t;

   // Rope position driven to the game logic
   typedef logic [9:0] rope_loc_t;

   // Register byte address within the peripheral
   typedef logic [3:0] apb_addr_t;

   // Needs to hold the digit limit itself
   typedef logic [$clog2(`RG_MAX_DIGITS + 1)-1:0] digit_cnt_t;

endpackage

`default_nettype wire

/* design/rope_consts.svh */
`ifndef ROPE_CONSTS_SVH
`define ROPE_CONSTS_SVH

//**************************************************************************
// Serial link
//**************************************************************************

// Clocks per oversample tick for 230400 baud at 100 MHz
`define RG_BAUD_DIV     27
`define RG_OVERSAMPLE   16
`define RG_DATA_BITS    8

//**************************************************************************
// Line format
//**************************************************************************

`define RG_MAX_DIGITS   8
`define RG_ASCII_CR     8'h0D
`define RG_ASCII_LF     8'h0A

// APB byte offsets
`define RG_OFS_ACCEL    4'h0
`define RG_OFS_ROPE     4'h4
`define RG_OFS_CTRL     4'h8
`define RG_OFS_STATUS   4'hC

`endif
